//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_lsu_mem
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_MSG   := Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
lsu_pkg.sv
mem_pkg.sv
byte_bank.sv
lsu_bank_decode.sv
lsu_load_align.sv
lsu_ctrl.sv
lsu_mem_top.sv
tb_clock.sv
tb_lsu_mem.sv

//--- byte_bank.sv
`timescale 1ns/1ps
`default_nettype none

module byte_bank
	import mem_pkg::*;
#(
	parameter int BANK_AW = 10
) (
	input  logic       i_clk,
	input  bank_port_t i_port_1,
	input  bank_port_t i_port_2,
	output mem_byte_t  o_rdata_1,
	output mem_byte_t  o_rdata_2
);

	localparam int DEPTH = 1 << BANK_AW;

	mem_byte_t          mem [DEPTH];
	logic [BANK_AW-1:0] idx_1;
	logic [BANK_AW-1:0] idx_2;

	assign idx_1 = i_port_1.idx[BANK_AW-1:0];
	assign idx_2 = i_port_2.idx[BANK_AW-1:0];

	// Reads see the old byte on a same-cycle write.
	always_ff @(posedge i_clk) begin
		o_rdata_1 <= mem[idx_1];
		o_rdata_2 <= mem[idx_2];
		if (i_port_1.we) begin
			mem[idx_1] <= i_port_1.data;
		end
		if (i_port_2.we) begin
			mem[idx_2] <= i_port_2.data;
		end
	end

	// Index must fit the port struct.
	assert property (@(posedge i_clk) BANK_AW <= BANK_AW_MAX)
		else $error("BANK_AW %0d exceeds %0d", BANK_AW, BANK_AW_MAX);

endmodule

`default_nettype wire

//--- lsu_bank_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_bank_decode
	import lsu_pkg::*, mem_pkg::*;
#(
	parameter int BANK_AW = 10
) (
	input  lsu_req_t   i_req,
	input  logic       i_en,
	output bank_port_t o_even_1,
	output bank_port_t o_even_2,
	output bank_port_t o_odd_1,
	output bank_port_t o_odd_2
);

	logic               odd;
	logic [BANK_AW-1:0] idx_0;
	logic [BANK_AW-1:0] idx_1;
	logic [BANK_AW-1:0] idx_2;
	logic [3:0]         lane_mask;
	logic [3:0]         lane_we;
	mem_byte_t [3:0]    lane_data;

	function automatic bank_port_t make_port(
		input logic [BANK_AW-1:0] idx,
		input mem_byte_t          data,
		input logic               we
	);
		bank_port_t port;
		port.idx  = bank_idx_t'(idx);
		port.data = we ? data : '0;
		port.we   = we;
		return port;
	endfunction

	assign odd   = i_req.addr[0];
	assign idx_0 = i_req.addr[BANK_AW:1];  // Half address, wraps with the bank.
	assign idx_1 = idx_0 + BANK_AW'(1);
	assign idx_2 = idx_0 + BANK_AW'(2);

	assign lane_data = i_req.wdata; // Lane k is byte k of the store.

	// Bytes touched, by access size.
	always_comb begin
		case (i_req.funct3)
			F3_LB, F3_LBU: lane_mask = 4'b0001;
			F3_LH, F3_LHU: lane_mask = 4'b0011;
			F3_LW:         lane_mask = 4'b1111;
			default:       lane_mask = 4'b0000;
		endcase
	end

	assign lane_we = {4{i_en & i_req.we}} & lane_mask;

	// Byte k always lands on address addr+k.
	always_comb begin
		if (!odd) begin
			o_even_1 = make_port(idx_0, lane_data[0], lane_we[0]);
			o_odd_1  = make_port(idx_0, lane_data[1], lane_we[1]);
			o_even_2 = make_port(idx_1, lane_data[2], lane_we[2]);
			o_odd_2  = make_port(idx_1, lane_data[3], lane_we[3]);
		end else begin
			o_odd_1  = make_port(idx_0, lane_data[0], lane_we[0]);
			o_even_1 = make_port(idx_1, lane_data[1], lane_we[1]);
			o_odd_2  = make_port(idx_1, lane_data[2], lane_we[2]);
			o_even_2 = make_port(idx_2, lane_data[3], lane_we[3]);
		end
	end

	// Both ports of one bank must never write the same byte.
	always_comb begin
		assert final (!(o_even_1.we && o_even_2.we && o_even_1.idx == o_even_2.idx))
			else $error("even bank ports write index %0d together", o_even_1.idx);
		assert final (!(o_odd_1.we && o_odd_2.we && o_odd_1.idx == o_odd_2.idx))
			else $error("odd bank ports write index %0d together", o_odd_1.idx);
	end

endmodule

`default_nettype wire

//--- lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl
	import lsu_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_req,
	input  lsu_req_t    i_lsu_req,
	input  lsu_word_t   i_ld_word,
	output logic        o_ack,
	output lsu_word_t   o_rdata,
	output logic        o_mem_en,
	output lsu_req_t    o_cur_req,
	output logic        o_rd_odd,
	output lsu_funct3_t o_rd_funct3
);

	typedef enum logic [2:0] {
		IDLE,
		ACCESS,   // Bank cycle.
		CAPTURE,  // Read data is in the bank registers.
		ACK,
		WAIT_LOW
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:     if (i_req) state_nxt = ACCESS;
			ACCESS:   state_nxt = CAPTURE;
			CAPTURE:  state_nxt = ACK;
			ACK:      state_nxt = i_req ? WAIT_LOW : IDLE;
			WAIT_LOW: if (!i_req) state_nxt = IDLE;
			default:  state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= IDLE;
			o_mem_en <= 1'b0;
			o_ack    <= 1'b0;
			o_rdata  <= '0;
		end else begin
			state    <= state_nxt;
			o_mem_en <= (state_nxt == ACCESS); // One pulse per request.
			if (state == CAPTURE) begin
				o_ack   <= 1'b1;
				o_rdata <= i_ld_word;
			end else if ((state == ACK || state == WAIT_LOW) && !i_req) begin
				o_ack <= 1'b0;
			end
		end
	end

	// Request and read context.
	always_ff @(posedge i_clk) begin
		if (state == IDLE && i_req) begin
			o_cur_req <= i_lsu_req;
		end
		if (state == ACCESS) begin
			o_rd_odd    <= o_cur_req.addr[0]; // Lines up with bank read data.
			o_rd_funct3 <= o_cur_req.funct3;
		end
	end

	// Four-phase rule, ack stays up until req is seen low.
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(o_ack) |-> !$past(i_req))
		else $error("o_ack fell while i_req was high");

	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_mem_en |-> state == ACCESS)
		else $error("o_mem_en high outside ACCESS");

endmodule

`default_nettype wire

//--- lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
	import lsu_pkg::*, mem_pkg::*;
(
	input  mem_byte_t   i_even_1,
	input  mem_byte_t   i_even_2,
	input  mem_byte_t   i_odd_1,
	input  mem_byte_t   i_odd_2,
	input  logic        i_odd,
	input  lsu_funct3_t i_funct3,
	output lsu_word_t   o_word
);

	mem_byte_t [3:0] bytes; // Index is the byte offset from the address.
	logic            sign_b;
	logic            sign_h;

	// Undo the bank mapping of the decoder.
	always_comb begin
		if (i_odd) begin
			bytes = {i_even_2, i_odd_2, i_even_1, i_odd_1};
		end else begin
			bytes = {i_odd_2, i_even_2, i_odd_1, i_even_1};
		end
	end

	assign sign_b = bytes[0][7];
	assign sign_h = bytes[1][7];

	always_comb begin
		case (i_funct3)
			F3_LB:   o_word = {{24{sign_b}}, bytes[0]};
			F3_LH:   o_word = {{16{sign_h}}, bytes[1], bytes[0]};
			F3_LW:   o_word = bytes;
			F3_LBU:  o_word = {24'b0, bytes[0]};
			F3_LHU:  o_word = {16'b0, bytes[1], bytes[0]};
			default: o_word = '0; // Unknown code loads zero.
		endcase
	end

endmodule

`default_nettype wire

//--- lsu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top
	import lsu_pkg::*, mem_pkg::*;
#(
	parameter int BANK_AW = 10
) (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_req,
	input  lsu_req_t  i_lsu_req,
	output logic      o_ack,
	output lsu_word_t o_rdata
);

	lsu_req_t    cur_req;
	logic        mem_en;
	logic        rd_odd;
	lsu_funct3_t rd_funct3;
	lsu_word_t   ld_word;
	bank_port_t  even_1;
	bank_port_t  even_2;
	bank_port_t  odd_1;
	bank_port_t  odd_2;
	mem_byte_t   rd_even_1;
	mem_byte_t   rd_even_2;
	mem_byte_t   rd_odd_1;
	mem_byte_t   rd_odd_2;

	lsu_ctrl u_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_req       (i_req),
		.i_lsu_req   (i_lsu_req),
		.i_ld_word   (ld_word),
		.o_ack       (o_ack),
		.o_rdata     (o_rdata),
		.o_mem_en    (mem_en),
		.o_cur_req   (cur_req),
		.o_rd_odd    (rd_odd),
		.o_rd_funct3 (rd_funct3)
	);

	lsu_bank_decode #(.BANK_AW(BANK_AW)) u_decode (
		.i_req    (cur_req),
		.i_en     (mem_en),
		.o_even_1 (even_1),
		.o_even_2 (even_2),
		.o_odd_1  (odd_1),
		.o_odd_2  (odd_2)
	);

	byte_bank #(.BANK_AW(BANK_AW)) u_bank_even (
		.i_clk     (i_clk),
		.i_port_1  (even_1),
		.i_port_2  (even_2),
		.o_rdata_1 (rd_even_1),
		.o_rdata_2 (rd_even_2)
	);

	byte_bank #(.BANK_AW(BANK_AW)) u_bank_odd (
		.i_clk     (i_clk),
		.i_port_1  (odd_1),
		.i_port_2  (odd_2),
		.o_rdata_1 (rd_odd_1),
		.o_rdata_2 (rd_odd_2)
	);

	lsu_load_align u_align (
		.i_even_1 (rd_even_1),
		.i_even_2 (rd_even_2),
		.i_odd_1  (rd_odd_1),
		.i_odd_2  (rd_odd_2),
		.i_odd    (rd_odd),
		.i_funct3 (rd_funct3),
		.o_word   (ld_word)
	);

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

// Types seen by the core side of the load/store unit.
package lsu_pkg;

	localparam int LSU_XLEN = 32;
	localparam int LSU_AW   = 11; // 2 KiB, byte addressed.

	typedef logic [LSU_XLEN-1:0] lsu_word_t;
	typedef logic [LSU_AW-1:0]   lsu_addr_t;
	typedef logic [2:0]          lsu_funct3_t;

	// RISC-V load codes. Stores reuse the size bits.
	localparam lsu_funct3_t F3_LB  = 3'b000;
	localparam lsu_funct3_t F3_LH  = 3'b001;
	localparam lsu_funct3_t F3_LW  = 3'b010;
	localparam lsu_funct3_t F3_LBU = 3'b100;
	localparam lsu_funct3_t F3_LHU = 3'b101;

	// One core request.
	typedef struct packed {
		lsu_addr_t   addr;
		lsu_word_t   wdata;
		lsu_funct3_t funct3;
		logic        we;     // Set for a store.
	} lsu_req_t;

endpackage

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

// Types seen by the byte banks.
package mem_pkg;

	// Widest bank index the port struct can carry.
	localparam int BANK_AW_MAX = 10;

	typedef logic [7:0]             mem_byte_t;
	typedef logic [BANK_AW_MAX-1:0] bank_idx_t;

	// One bank port, index is zero extended from BANK_AW bits.
	typedef struct packed {
		bank_idx_t idx;
		mem_byte_t data;
		logic      we;
	} bank_port_t;

endpackage

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS  = 100,
	parameter int RST_CYCLES = 10
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk   = 1'b0;
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1; // Release on a rising edge.
	end

	always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- tb_lsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_mem
	import lsu_pkg::*;
();

	localparam int CLK_PERIOD_NS = 100;
	localparam int RST_CYCLES    = 10;
	localparam int ACK_LATENCY   = 3;  // Edges from driving req to o_ack high.
	localparam int ACK_LIMIT     = 10;
	localparam int N_INIT        = 512;
	localparam int N_WORD        = 64;
	localparam int N_PART        = 64;
	localparam int N_EXT         = 48;
	localparam int N_WRAP        = 3;
	localparam int N_BAD         = 18;
	localparam int N_REQ = N_INIT + 3 * N_WORD + 3 * N_PART + 5 * N_EXT + 6 * N_WRAP + 3 * N_BAD;
	localparam int WATCHDOG_CYCLES = N_REQ * 20 + RST_CYCLES;

	logic        clk;
	logic        rst_n;
	logic        req;
	lsu_req_t    lsu_req;
	logic        ack;
	lsu_word_t   rdata;
	logic [7:0]  ref_mem [2048]; // Byte-addressed reference model.
	logic [31:0] lfsr_state;
	int          data_errors;
	int          proto_errors;
	int          req_count;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(RST_CYCLES)) u_clock (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	lsu_mem_top #(.BANK_AW(10)) i_lsu_mem_top (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_req     (req),
		.i_lsu_req (lsu_req),
		.o_ack     (ack),
		.o_rdata   (rdata)
	);

	// Galois step with taps 32, 31, 29 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int access_size(input lsu_funct3_t f3);
		case (f3)
			F3_LB, F3_LBU: return 1;
			F3_LH, F3_LHU: return 2;
			F3_LW:         return 4;
			default:       return 0; // Unused codes touch nothing.
		endcase
	endfunction

	function automatic void model_store(input lsu_addr_t addr, input lsu_funct3_t f3,
			input lsu_word_t data);
		for (int k = 0; k < access_size(f3); k++) begin
			ref_mem[addr + lsu_addr_t'(k)] = data[8*k +: 8]; // Wraps at 2048.
		end
	endfunction

	function automatic lsu_word_t model_load(input lsu_addr_t addr, input lsu_funct3_t f3);
		logic [31:0] w;
		for (int k = 0; k < 4; k++) begin
			w[8*k +: 8] = ref_mem[addr + lsu_addr_t'(k)];
		end
		case (f3)
			F3_LB:   return {{24{w[7]}}, w[7:0]};
			F3_LH:   return {{16{w[15]}}, w[15:0]};
			F3_LW:   return w;
			F3_LBU:  return {24'b0, w[7:0]};
			F3_LHU:  return {16'b0, w[15:0]};
			default: return '0;
		endcase
	endfunction

	// One four-phase handshake with its timing checked.
	task automatic run_request(input lsu_req_t r, output lsu_word_t data);
		int   edges;
		int   hold;
		logic seen;
		edges = 0;
		seen  = 1'b0;
		data  = '0;
		req_count++;
		@(posedge clk);
		req     <= 1'b1;
		lsu_req <= r;
		while (!seen && edges < ACK_LIMIT) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			seen = ack;
		end
		if (!seen) begin
			$display("Error at %0t: no o_ack within %0d cycles of a request", $time, ACK_LIMIT);
			proto_errors++;
		end else begin
			if (edges != ACK_LATENCY) begin
				$display("FAIL %0t: o_ack latency expected %0d, got %0d", $time, ACK_LATENCY, edges);
				proto_errors++;
			end
			data = rdata;
			hold = int'(rand_bits(3) % 6);
			repeat (hold) begin
				@(posedge clk);
				@(negedge clk);
				if (ack !== 1'b1) begin
					$display("FAIL %0t: o_ack expected 1, got %b", $time, ack);
					proto_errors++;
				end
				if (rdata !== data) begin
					$display("FAIL %0t: o_rdata expected %h, got %h", $time, data, rdata);
					proto_errors++;
				end
			end
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		// Req was still sampled high at this edge.
		if (seen && ack !== 1'b1) begin
			$display("FAIL %0t: o_ack expected 1, got %b", $time, ack);
			proto_errors++;
		end
		if (seen && rdata !== data) begin
			$display("FAIL %0t: o_rdata expected %h, got %h", $time, data, rdata);
			proto_errors++;
		end
		@(posedge clk);
		@(negedge clk);
		if (ack !== 1'b0) begin
			$display("FAIL %0t: o_ack expected 0, got %b", $time, ack);
			proto_errors++;
		end
	endtask

	task automatic store(input lsu_addr_t addr, input lsu_funct3_t f3, input lsu_word_t wdata);
		lsu_req_t  r;
		lsu_word_t ignored;
		r.addr   = addr;
		r.wdata  = wdata;
		r.funct3 = f3;
		r.we     = 1'b1;
		run_request(r, ignored);
		model_store(addr, f3, wdata);
	endtask

	task automatic load_check(input lsu_addr_t addr, input lsu_funct3_t f3);
		lsu_req_t  r;
		lsu_word_t got;
		lsu_word_t exp;
		r.addr   = addr;
		r.wdata  = '0;
		r.funct3 = f3;
		r.we     = 1'b0;
		exp = model_load(addr, f3);
		run_request(r, got);
		if (got !== exp) begin
			$display("FAIL %0t: o_rdata expected %h, got %h (addr %0d, funct3 %b)",
				$time, exp, got, addr, f3);
			data_errors++;
		end
	endtask

	initial begin
		lsu_addr_t   addr;
		lsu_funct3_t f3;
		lsu_funct3_t bad_codes [3];
		req          = 1'b0;
		lsu_req      = '0;
		lfsr_state   = 32'h28d8_f5ce;
		data_errors  = 0;
		proto_errors = 0;
		req_count    = 0;
		bad_codes    = '{3'b011, 3'b110, 3'b111};
		for (int i = 0; i < 2048; i++) begin
			ref_mem[i] = '0;
		end
		@(posedge rst_n);
		@(negedge clk);
		if (ack !== 1'b0) begin
			$display("FAIL %0t: o_ack expected 0, got %b", $time, ack);
			proto_errors++;
		end
		if (rdata !== '0) begin
			$display("FAIL %0t: o_rdata expected 0, got %h", $time, rdata);
			proto_errors++;
		end
		// Fill every byte so no load sees uninitialized bank memory.
		for (int i = 0; i < N_INIT; i++) begin
			store(lsu_addr_t'(4 * i), F3_LW, rand_bits(32));
		end
		for (int i = 0; i < N_WORD; i++) begin
			addr = lsu_addr_t'(rand_bits(11));
			if (rand_bits(1)) begin
				addr[1:0] = 2'b00; // Aligned about half the time.
			end
			store(addr, F3_LW, rand_bits(32));
			load_check(addr, F3_LW);
			load_check(lsu_addr_t'(rand_bits(11)), F3_LW);
		end
		for (int i = 0; i < N_PART; i++) begin
			addr = lsu_addr_t'(rand_bits(11));
			f3   = rand_bits(1) ? F3_LH : F3_LB;
			store(addr, f3, rand_bits(32));
			load_check({addr[10:2], 2'b00}, F3_LW); // Surrounding word.
			load_check(addr, F3_LW);
		end
		for (int i = 0; i < N_EXT; i++) begin
			addr = lsu_addr_t'(rand_bits(11));
			store(addr, F3_LW, rand_bits(32));
			load_check(addr, F3_LB);
			load_check(addr, F3_LH);
			load_check(addr, F3_LBU);
			load_check(addr, F3_LHU);
		end
		// Accesses that run off the top of memory.
		for (int i = 0; i < N_WRAP; i++) begin
			addr = lsu_addr_t'(2045 + i);
			store(addr, F3_LW, rand_bits(32));
			load_check(addr, F3_LW);
			load_check('0, F3_LW);
			store(addr, F3_LH, rand_bits(32));
			load_check(addr, F3_LH);
			load_check(addr, F3_LHU);
		end
		for (int i = 0; i < N_BAD; i++) begin
			addr = lsu_addr_t'(rand_bits(11));
			store(addr, bad_codes[i % 3], rand_bits(32));
			load_check(addr, F3_LW);
			load_check(addr, bad_codes[i % 3]);
		end
		$display("Errors: %0d data, %0d handshake, over %0d requests",
			data_errors, proto_errors, req_count);
		if (data_errors + proto_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
